// ==== Bender.yml ====
package:
  name: pwm_timer

sources:
  - common/timer_pkg.sv
  - timer/timer_regs.sv
  - timer/timer_counter.sv
  - timer/timer_channel.sv
  - verilog/pwm_timer.sv
  - target: test
    files:
      - bench/pwm_timer_asserts.sv
      - bench/pwm_timer_checker.sv
      - bench/pwm_timer_tb.sv

// ==== bench/pwm_timer_asserts.sv ====
// PWM timer assertions
`timescale 1ns/100ps

module pwm_timer_asserts import timer_pkg::*; (
	input logic             HCLK,
	input logic             HRESETn,
	input logic             pready_i,
	input logic             pslverr_i,
	input timer_cfg_t       cfg_i,
	input timer_cmd_t       cmd_i,
	input logic [CNT_W-1:0] counter_i
);

	logic running; // Follows the start and stop pulses
	int   assert_errors = 0;

	always_ff @(posedge HCLK, negedge HRESETn)
	begin
		if (!HRESETn)
			running <= 1'b0;
		else if (cmd_i.stop)
			running <= 1'b0;
		else if (cmd_i.start)
			running <= 1'b1;
	end

	a_bus_resp: assert property (@(posedge HCLK) disable iff (!HRESETn)
		pready_i && !pslverr_i)
	else
	begin
		$error("APB slave answered with wait state or error");
		assert_errors++;
	end

	a_cmd_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(cmd_i != '0) |=> ((cmd_i & $past(cmd_i)) == '0))
	else
	begin
		$error("command pulse held for two cycles");
		assert_errors++;
	end

	a_cnt_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
		running |-> (counter_i >= cfg_i.th_low && counter_i <= cfg_i.th_high))
	else
	begin
		$error("counter left the threshold range while running");
		assert_errors++;
	end

endmodule

// ==== bench/pwm_timer_checker.sv ====
// PWM timer response checker
`timescale 1ns/100ps

module pwm_timer_checker (
	input  logic        HCLK,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [31:0] prdata_i,
	input  logic [1:0]  pwm_i,
	input  logic        event_i,
	input  logic        read_exp_i,
	input  logic        meas_start_i,
	input  logic [11:0] sel_i,
	input  logic [31:0] arg_i,
	input  logic [31:0] exp_i,
	output logic        busy_o,
	output int          read_errors_o,
	output int          meas_errors_o
);

	typedef enum logic [1:0] {IDLE, WAIT_EVENT, PERIOD, WINDOW} meas_state_t;

	meas_state_t state = IDLE;
	logic [11:0] kind;
	logic [31:0] window;
	logic [31:0] expected;
	logic [31:0] last_read = '0;
	logic [1:0]  pwm_prev = '0;
	int          elapsed, cycles, high0, high1, edges;
	int          read_errors = 0;
	int          meas_errors = 0;

	function automatic string meas_name(input logic [11:0] k);
		case (k)
			12'd0:   return "event_o period";
			12'd1:   return "pwm_o[0] high";
			12'd2:   return "pwm_o[1] high";
			12'd3:   return "pwm_o[0] edges";
			default: return "pwm_o changes";
		endcase
	endfunction

	task automatic compare_measure(input int got);
		if (got != expected)
		begin
			$display("mismatch %s exp %h got %h", meas_name(kind), expected, got);
			meas_errors++;
		end
	endtask

	task automatic accumulate();
		cycles++;
		high0 += pwm_i[0];
		high1 += pwm_i[1];
		edges += (pwm_i[0] != pwm_prev[0]);
	endtask

	always @(posedge HCLK)
	begin
		//////////////////////////////////////////////////
		// Read data in the access cycle
		//////////////////////////////////////////////////
		if (read_exp_i && psel_i && penable_i && !pwrite_i)
		begin
			if (arg_i[1:0] == 2'd0 && prdata_i !== exp_i)
			begin
				$display("mismatch prdata_o exp %h got %h", exp_i, prdata_i);
				read_errors++;
			end
			else if (arg_i[1:0] == 2'd1 && prdata_i !== last_read)
			begin
				$display("mismatch prdata_o exp %h got %h", last_read, prdata_i);
				read_errors++;
			end
			last_read = prdata_i;
		end

		//////////////////////////////////////////////////
		// Output measurements
		//////////////////////////////////////////////////
		case (state)
			IDLE:
				if (meas_start_i)
				begin
					kind     = sel_i;
					window   = arg_i;
					expected = exp_i;
					elapsed  = 0;
					cycles   = 0;
					high0    = 0;
					high1    = 0;
					edges    = 0;
					state    = (sel_i == 12'd4) ? WINDOW : WAIT_EVENT;
				end
			WAIT_EVENT:
			begin
				elapsed++;
				if (event_i)
				begin
					accumulate(); // Period starts at this pulse
					state = PERIOD;
				end
				else if (elapsed >= window)
				begin
					$display("%s: no event_o pulse within %0d cycles", meas_name(kind), window);
					meas_errors++;
					state = IDLE;
				end
			end
			PERIOD:
			begin
				elapsed++;
				if (event_i)
				begin
					case (kind)
						12'd0:   compare_measure(cycles);
						12'd1:   compare_measure(high0);
						12'd2:   compare_measure(high1);
						default: compare_measure(edges);
					endcase
					state = IDLE;
				end
				else if (elapsed >= window)
				begin
					$display("%s: second event_o pulse missing after %0d cycles",
						meas_name(kind), window);
					meas_errors++;
					state = IDLE;
				end
				else
					accumulate();
			end
			WINDOW:
			begin
				elapsed++;
				edges += (pwm_i != pwm_prev); // Any channel change
				if (elapsed >= window)
				begin
					compare_measure(edges);
					state = IDLE;
				end
			end
			default:
				state = IDLE;
		endcase
		pwm_prev = pwm_i;
	end

	assign busy_o        = (state != IDLE);
	assign read_errors_o = read_errors;
	assign meas_errors_o = meas_errors;

endmodule

// ==== bench/pwm_timer_input.txt ====
# op addr data expect (hex); op W write, R read, M measure
# R data 0 compare, 1 same as last read, 2 capture; M addr 0 period 1/2 high 3 edges 4 changes
R 004 0 00001000
R 008 0 00000000
R 00C 0 00000000
R 010 0 00000000
R 02C 0 00000000
# register readback
W 004 FFFFFFFF 0
R 004 0 00FF1000
W 008 00140004 0
R 008 0 00140004
W 00C FFFE0008 0
R 00C 0 00020008
W 010 0003000C 0
R 010 0 0003000C
R 000 0 00000000
R 014 0 00000000
R FFC 0 00000000
# sawtooth, presc 1, range 4 to 20
W 004 00011000 0
R 004 0 00011000
W 000 00000008 0
W 000 00000001 0
M 0 80 00000022
M 1 80 00000018
M 2 80 00000012
# up-down, presc 2, channel 0 toggles at 8
W 000 00000002 0
W 004 00020000 0
W 00C 00010008 0
W 000 00000008 0
W 000 00000001 0
M 0 180 00000060
M 3 180 00000002
# stop and counter reset
W 000 00000002 0
R 02C 2 00000000
R 02C 1 00000000
M 4 28 00000000
R 02C 1 00000000
W 000 00000008 0
R 02C 0 00000004

// ==== bench/pwm_timer_tb.sv ====
// PWM timer testbench
`timescale 1ns/100ps

module pwm_timer_tb import timer_pkg::*; ;

	typedef struct packed {
		logic [7:0]        op;
		logic [ADDR_W-1:0] addr;
		logic [31:0]       data;
		logic [31:0]       exp;
	} step_t;

	logic              HCLK;
	logic              HRESETn;
	logic              psel, penable, pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [31:0]       pwdata, prdata;
	logic              pready, pslverr;
	logic [N_CH-1:0]   pwm;
	logic              evt;
	logic              read_exp, meas_start, busy;
	logic [11:0]       exp_sel;
	logic [31:0]       exp_arg, exp_value;
	int                read_errors, meas_errors;
	int                assert_errors;
	int                bench_errors = 0;
	longint            watchdog_ns = 0;
	longint            window_sum;
	step_t             steps[$];

	pwm_timer pwm_timer_i (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.pwm_o     (pwm),
		.event_o   (evt)
	);

	pwm_timer_checker pwm_timer_checker_i (
		.HCLK          (HCLK),
		.psel_i        (psel),
		.penable_i     (penable),
		.pwrite_i      (pwrite),
		.prdata_i      (prdata),
		.pwm_i         (pwm),
		.event_i       (evt),
		.read_exp_i    (read_exp),
		.meas_start_i  (meas_start),
		.sel_i         (exp_sel),
		.arg_i         (exp_arg),
		.exp_i         (exp_value),
		.busy_o        (busy),
		.read_errors_o (read_errors),
		.meas_errors_o (meas_errors)
	);

	bind pwm_timer pwm_timer_asserts pwm_timer_asserts_i (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.pready_i  (pready_o),
		.pslverr_i (pslverr_o),
		.cfg_i     (cfg),
		.cmd_i     (cmd),
		.counter_i (counter)
	);

	assign assert_errors = pwm_timer_i.pwm_timer_asserts_i.assert_errors;

	always #2 HCLK = ~HCLK;

	task automatic load_steps();
		int                fd;
		int                n;
		string             line;
		logic [7:0]        op;
		logic [ADDR_W-1:0] addr;
		logic [31:0]       data, exp;
		fd = $fopen("bench/pwm_timer_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file bench/pwm_timer_input.txt");
			bench_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "#")
				continue; // Blank or comment
			n = $sscanf(line, "%c %h %h %h", op, addr, data, exp);
			if (n != 4)
			begin
				$display("stimulus line could not be parsed: %s", line);
				bench_errors++;
			end
			else
				steps.push_back('{op, addr, data, exp});
		end
		$fclose(fd);
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge HCLK);
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = addr;
		pwdata = data;
		@(negedge HCLK);
		penable = 1'b1;
		@(negedge HCLK);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] mode,
		input logic [31:0] exp);
		@(negedge HCLK);
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = addr;
		@(negedge HCLK);
		penable   = 1'b1;
		read_exp  = 1'b1;
		exp_arg   = mode;
		exp_value = exp;
		@(negedge HCLK);
		psel     = 1'b0;
		penable  = 1'b0;
		read_exp = 1'b0;
	endtask

	task automatic measure_output(input logic [11:0] kind, input logic [31:0] window,
		input logic [31:0] exp);
		@(negedge HCLK);
		meas_start = 1'b1;
		exp_sel    = kind;
		exp_arg    = window;
		exp_value  = exp;
		@(negedge HCLK);
		meas_start = 1'b0;
		while (busy)
			@(negedge HCLK);
	endtask

	task automatic run_step(input step_t s);
		case (s.op)
			"W": write_reg(s.addr, s.data);
			"R": read_reg(s.addr, s.data, s.exp);
			"M": measure_output(s.addr, s.data, s.exp);
			default:
			begin
				$display("unknown operation %c in the stimulus file", s.op);
				bench_errors++;
			end
		endcase
	endtask

	initial
	begin
		HCLK       = 1'b0;
		HRESETn    = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		read_exp   = 1'b0;
		meas_start = 1'b0;
		exp_sel    = '0;
		exp_arg    = '0;
		exp_value  = '0;
		load_steps();
		window_sum = 0;
		foreach (steps[i])
			if (steps[i].op == "M")
				window_sum += steps[i].data;
		watchdog_ns = (steps.size() * 64 + window_sum) * 4;
		repeat (2) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;
		foreach (steps[i])
			run_step(steps[i]);
		repeat (4) @(negedge HCLK);
		$display("errors: read %0d, measure %0d, bench %0d, assertion %0d", read_errors,
			meas_errors, bench_errors, assert_errors);
		if (read_errors + meas_errors + bench_errors + assert_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog sized from the stimulus length
	initial
	begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== common/timer_pkg.sv ====
// PWM timer shared definitions
package timer_pkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////
	localparam int CNT_W   = 16;
	localparam int PRESC_W = 8;
	localparam int N_CH    = 2;
	localparam int ADDR_W  = 12;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////
	localparam logic [ADDR_W-1:0] REG_CMD     = 12'h000;
	localparam logic [ADDR_W-1:0] REG_CFG     = 12'h004;
	localparam logic [ADDR_W-1:0] REG_TH      = 12'h008;
	localparam logic [ADDR_W-1:0] REG_CH0_TH  = 12'h00C;
	localparam logic [ADDR_W-1:0] REG_CH1_TH  = 12'h010;
	localparam logic [ADDR_W-1:0] REG_COUNTER = 12'h02C;

	// Channel register per index
	localparam logic [N_CH-1:0][ADDR_W-1:0] REG_CH_TH = {REG_CH1_TH, REG_CH0_TH};

	// Command and field bit positions
	localparam int CMD_START     = 0;
	localparam int CMD_STOP      = 1;
	localparam int CMD_RST       = 3;
	localparam int CFG_SAW_BIT   = 12;
	localparam int CFG_PRESC_LSB = 16;
	localparam int CH_MODE_LSB   = 16;

	typedef enum logic [1:0] {
		OUT_SET     = 2'd0, // Set on match
		OUT_TOGGLE  = 2'd1,
		OUT_SET_CLR = 2'd2, // Cleared at period end
		OUT_CLR_SET = 2'd3  // Set at period end
	} ch_mode_t;

	typedef struct packed {
		logic [PRESC_W-1:0] presc;
		logic               saw;     // 1 sawtooth, 0 up-down
		logic [CNT_W-1:0]   th_low;
		logic [CNT_W-1:0]   th_high;
	} timer_cfg_t;

	typedef struct packed {
		logic [CNT_W-1:0] th;
		ch_mode_t         mode;
	} ch_cfg_t;

	typedef struct packed {
		logic start;
		logic stop;
		logic rst;
	} timer_cmd_t;

endpackage

// ==== pwm_timer.f ====
common/timer_pkg.sv
timer/timer_regs.sv
timer/timer_counter.sv
timer/timer_channel.sv
verilog/pwm_timer.sv
bench/pwm_timer_asserts.sv
bench/pwm_timer_checker.sv
bench/pwm_timer_tb.sv

// ==== timer/timer_channel.sv ====
// Compare channel with PWM output
`timescale 1ns/100ps

module timer_channel import timer_pkg::*; (
	input  logic             HCLK,
	input  logic             HRESETn,
	input  ch_cfg_t          ch_cfg_i,
	input  logic [CNT_W-1:0] counter_i,
	input  logic             tick_i,
	input  logic             period_end_i,
	output logic             pwm_o
);

	logic match;
	logic pwm_q;

	assign match = tick_i && (counter_i == ch_cfg_i.th);

	always_ff @(posedge HCLK, negedge HRESETn)
	begin
		if (!HRESETn)
			pwm_q <= 1'b0;
		else if (match) // Match has priority over period end
		begin
			case (ch_cfg_i.mode)
				OUT_SET:     pwm_q <= 1'b1;
				OUT_TOGGLE:  pwm_q <= ~pwm_q;
				OUT_SET_CLR: pwm_q <= 1'b1;
				OUT_CLR_SET: pwm_q <= 1'b0;
				default:     pwm_q <= pwm_q;
			endcase
		end
		else if (period_end_i)
		begin
			case (ch_cfg_i.mode)
				OUT_SET_CLR: pwm_q <= 1'b0;
				OUT_CLR_SET: pwm_q <= 1'b1;
				default:     pwm_q <= pwm_q;
			endcase
		end
	end

	assign pwm_o = pwm_q;

endmodule

// ==== timer/timer_counter.sv ====
// Prescaler and up/down counter
`timescale 1ns/100ps

module timer_counter import timer_pkg::*; (
	input  logic             HCLK,
	input  logic             HRESETn,
	input  timer_cfg_t       cfg_i,
	input  timer_cmd_t       cmd_i,
	output logic [CNT_W-1:0] counter_o,
	output logic             tick_o,
	output logic             period_end_o
);

	logic               running_q, running_d;
	logic               down_q, down_d;
	logic               tick_q, tick_d;
	logic               pend_q, pend_d;
	logic [PRESC_W-1:0] presc_q, presc_d;
	logic [CNT_W-1:0]   counter_q, counter_d;

	// Strobes are registered ahead, high in the last cycle of each count
	always_comb
	begin
		running_d = running_q;
		presc_d   = presc_q;
		down_d    = down_q;
		counter_d = counter_q;
		if (cmd_i.start)
			running_d = 1'b1;
		if (cmd_i.stop)
			running_d = 1'b0;
		if (cmd_i.rst)
		begin
			presc_d   = '0;
			down_d    = 1'b0;
			counter_d = cfg_i.th_low;
		end
		else if (tick_q)
		begin
			presc_d = '0;
			if (cfg_i.saw)
			begin
				down_d    = 1'b0;
				counter_d = (counter_q >= cfg_i.th_high) ? cfg_i.th_low : counter_q + 1'b1;
			end
			else if (!down_q)
			begin
				down_d    = (counter_q >= cfg_i.th_high); // Turn at top
				counter_d = down_d ? counter_q - 1'b1 : counter_q + 1'b1;
			end
			else
			begin
				down_d    = (counter_q > cfg_i.th_low); // Turn at bottom
				counter_d = down_d ? counter_q - 1'b1 : counter_q + 1'b1;
			end
		end
		else if (running_q)
			presc_d = presc_q + 1'b1;

		tick_d = running_d && (presc_d >= cfg_i.presc);
		if (cfg_i.saw)
			pend_d = tick_d && (counter_d >= cfg_i.th_high); // Wrap tick
		else
			pend_d = tick_d && (counter_d <= cfg_i.th_low);
	end

	always_ff @(posedge HCLK, negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			running_q <= 1'b0;
			down_q    <= 1'b0;
			tick_q    <= 1'b0;
			pend_q    <= 1'b0;
			presc_q   <= '0;
			counter_q <= '0;
		end
		else
		begin
			running_q <= running_d;
			down_q    <= down_d;
			tick_q    <= tick_d;
			pend_q    <= pend_d;
			presc_q   <= presc_d;
			counter_q <= counter_d;
		end
	end

	assign counter_o    = counter_q;
	assign tick_o       = tick_q;
	assign period_end_o = pend_q;

endmodule

// ==== timer/timer_regs.sv ====
// APB register bank
`timescale 1ns/100ps

module timer_regs import timer_pkg::*; (
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  logic [ADDR_W-1:0]      paddr_i,
	input  logic [31:0]            pwdata_i,
	input  logic [CNT_W-1:0]       counter_i,
	output logic [31:0]            prdata_o,
	output logic                   pready_o,
	output logic                   pslverr_o,
	output timer_cfg_t             cfg_o,
	output timer_cmd_t             cmd_o,
	output ch_cfg_t [N_CH-1:0]     ch_cfg_o
);

	logic [ADDR_W-1:0]  reg_addr;
	logic               wr_en;
	timer_cfg_t         cfg_q;
	timer_cmd_t         cmd_q;
	ch_cfg_t [N_CH-1:0] ch_q;

	assign reg_addr = {paddr_i[ADDR_W-1:2], 2'b00}; // Word aligned
	assign wr_en    = psel_i & penable_i & pwrite_i;

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK, negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			cfg_q <= '{presc: '0, saw: 1'b1, th_low: '0, th_high: '0};
			cmd_q <= '0;
			ch_q  <= '0;
		end
		else
		begin
			cmd_q <= '0; // Pulses drop after one cycle
			if (wr_en)
			begin
				case (reg_addr)
					REG_CMD:
					begin
						cmd_q.start <= pwdata_i[CMD_START];
						cmd_q.stop  <= pwdata_i[CMD_STOP];
						cmd_q.rst   <= pwdata_i[CMD_RST];
					end
					REG_CFG:
					begin
						cfg_q.presc <= pwdata_i[CFG_PRESC_LSB +: PRESC_W];
						cfg_q.saw   <= pwdata_i[CFG_SAW_BIT];
					end
					REG_TH:
					begin
						cfg_q.th_low  <= pwdata_i[CNT_W-1:0];
						cfg_q.th_high <= pwdata_i[2*CNT_W-1:CNT_W];
					end
					default:
					begin
					end
				endcase
				for (int i = 0; i < N_CH; i++)
				begin
					if (reg_addr == REG_CH_TH[i])
					begin
						ch_q[i].th   <= pwdata_i[CNT_W-1:0];
						ch_q[i].mode <= ch_mode_t'(pwdata_i[CH_MODE_LSB +: 2]);
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////
	always_comb
	begin
		prdata_o = '0; // CMD and holes read zero
		case (reg_addr)
			REG_CFG:
			begin
				prdata_o[CFG_PRESC_LSB +: PRESC_W] = cfg_q.presc;
				prdata_o[CFG_SAW_BIT]              = cfg_q.saw;
			end
			REG_TH:
				prdata_o = {cfg_q.th_high, cfg_q.th_low};
			REG_COUNTER:
				prdata_o[CNT_W-1:0] = counter_i;
			default:
			begin
			end
		endcase
		for (int i = 0; i < N_CH; i++)
		begin
			if (reg_addr == REG_CH_TH[i])
			begin
				prdata_o[CNT_W-1:0]        = ch_q[i].th;
				prdata_o[CH_MODE_LSB +: 2] = ch_q[i].mode;
			end
		end
	end

	assign cfg_o     = cfg_q;
	assign cmd_o     = cmd_q;
	assign ch_cfg_o  = ch_q;
	assign pready_o  = 1'b1; // Zero wait states
	assign pslverr_o = 1'b0;

endmodule

// ==== verilog/pwm_timer.sv ====
// PWM timer top level
`timescale 1ns/100ps

module pwm_timer import timer_pkg::*; (
	input  logic              HCLK,
	input  logic              HRESETn,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [ADDR_W-1:0] paddr_i,
	input  logic [31:0]       pwdata_i,
	output logic [31:0]       prdata_o,
	output logic              pready_o,
	output logic              pslverr_o,
	output logic [N_CH-1:0]   pwm_o,
	output logic              event_o
);

	timer_cfg_t         cfg;
	timer_cmd_t         cmd;
	ch_cfg_t [N_CH-1:0] ch_cfg;
	logic [CNT_W-1:0]   counter;
	logic               tick;
	logic               period_end;

	timer_regs timer_regs_i (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.counter_i (counter),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.cfg_o     (cfg),
		.cmd_o     (cmd),
		.ch_cfg_o  (ch_cfg)
	);

	timer_counter timer_counter_i (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.cfg_i        (cfg),
		.cmd_i        (cmd),
		.counter_o    (counter),
		.tick_o       (tick),
		.period_end_o (period_end)
	);

	for (genvar i = 0; i < N_CH; i++)
	begin : g_ch
		timer_channel timer_channel_i (
			.HCLK         (HCLK),
			.HRESETn      (HRESETn),
			.ch_cfg_i     (ch_cfg[i]),
			.counter_i    (counter),
			.tick_i       (tick),
			.period_end_i (period_end),
			.pwm_o        (pwm_o[i])
		);
	end

	assign event_o = period_end; // Already a flop output

endmodule
